// File: hdl/alu.sv
`timescale 1ns/1ps
`default_nettype none

module alu import exec_pkg::*; (
    input  alu_op_e         alu_op_i,
    input  logic            word_i,
    input  logic [XLEN-1:0] src1_i,
    input  logic [XLEN-1:0] src2_i,
    output logic [XLEN-1:0] result_o,
    output logic            less_o,
    output logic            zero_o
);

    logic               sub;
    logic               uns;
    logic               right;
    logic               arith;

    logic [XLEN-1:0]    add_sum;
    logic               add_carry;
    logic               add_ovf;

    logic [XLEN-1:0]    shift_src;
    logic [SHAMT_W-1:0] shamt;
    logic [XLEN-1:0]    shift_res;

    logic [XLEN-1:0]    raw;

    // internal controls straight from the op bits
    assign sub   = alu_op_i[1] | alu_op_i[3];
    assign uns   = alu_op_i[3];
    assign right = alu_op_i[2];
    assign arith = alu_op_i[3];

    alu_adder i_alu_adder (
        .src1_i     (src1_i),
        .src2_i     (src2_i ^ {XLEN{sub}}),
        .cin_i      (sub),
        .sum_o      (add_sum),
        .carry_o    (add_carry),
        .overflow_o (add_ovf),
        .zero_o     (zero_o)
    );

    // word forms shift only the low half by at most 31
    always_comb begin
        shamt     = src2_i[SHAMT_W-1:0];
        shift_src = src1_i;
        if (word_i) begin
            shamt[SHAMT_W-1] = 1'b0;
            if (right) begin
                // zero-extend for srlw, sign-extend for sraw
                shift_src = {{(XLEN-WORD_W){arith & src1_i[WORD_W-1]}}, src1_i[WORD_W-1:0]};
            end
        end
    end

    alu_shifter i_alu_shifter (
        .data_i  (shift_src),
        .shamt_i (shamt),
        .right_i (right),
        .arith_i (arith),
        .data_o  (shift_res)
    );

    // no borrow means carry set, so less is carry flipped by cin
    assign less_o = uns ? (add_carry ^ sub) : (add_sum[XLEN-1] ^ add_ovf);

    always_comb begin
        case (alu_op_i[2:0])
            3'h0:       raw = add_sum;
            3'h1, 3'h5: raw = shift_res;
            3'h2:       raw = {{(XLEN-1){1'b0}}, less_o};
            3'h3:       raw = src2_i;
            3'h4:       raw = src1_i ^ src2_i;
            3'h6:       raw = src1_i | src2_i;
            default:    raw = src1_i & src2_i;
        endcase
    end

    // sign-extend bit 31 for the *W forms
    assign result_o = word_i ? {{(XLEN-WORD_W){raw[WORD_W-1]}}, raw[WORD_W-1:0]} : raw;

endmodule

`default_nettype wire

// File: hdl/alu_adder.sv
`timescale 1ns/1ps
`default_nettype none

module alu_adder import exec_pkg::*; (
    input  logic [XLEN-1:0] src1_i,
    input  logic [XLEN-1:0] src2_i,
    input  logic            cin_i,
    output logic [XLEN-1:0] sum_o,
    output logic            carry_o,
    output logic            overflow_o,
    output logic            zero_o
);

    logic [XLEN:0] sum_ext;

    // one add, carry-out lands in the extra msb
    assign sum_ext = {1'b0, src1_i} + {1'b0, src2_i} + {{XLEN{1'b0}}, cin_i};

    assign sum_o   = sum_ext[XLEN-1:0];
    assign carry_o = sum_ext[XLEN];

    // same operand signs but result sign differs
    assign overflow_o = (src1_i[XLEN-1] == src2_i[XLEN-1]) &&
                        (sum_o[XLEN-1] != src1_i[XLEN-1]);

    // equality test when subtracting
    assign zero_o = ~(|sum_o);

endmodule

`default_nettype wire

// File: hdl/alu_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module alu_ctrl import exec_pkg::*; (
    input  inst_class_e cls_i,
    input  logic [2:0]  funct3_i,
    input  logic        funct7_5_i,
    output alu_op_e     alu_op_o,
    output logic        word_o,
    output logic        src1_pc_o,
    output logic        src2_imm_o,
    output br_sel_e     br_sel_o,
    output logic        illegal_o
);

    // common funct3 table, mod picks sub or sra
    function automatic alu_op_e base_op(input logic [2:0] f3, input logic mod);
        alu_op_e op;
        case (f3)
            3'b000:  op = mod ? ALU_SUB : ALU_ADD;
            3'b001:  op = ALU_SLL;
            3'b010:  op = ALU_SLT;
            3'b011:  op = ALU_SLTU;
            3'b100:  op = ALU_XOR;
            3'b101:  op = mod ? ALU_SRA : ALU_SRL;
            3'b110:  op = ALU_OR;
            default: op = ALU_AND;
        endcase
        return op;
    endfunction

    always_comb begin
        alu_op_o   = ALU_ADD;
        word_o     = 1'b0;
        src1_pc_o  = 1'b0;
        src2_imm_o = 1'b0;
        br_sel_o   = BR_NONE;
        illegal_o  = 1'b0;

        case (cls_i)
            CLS_OP: begin
                alu_op_o  = base_op(funct3_i, funct7_5_i);
                illegal_o = funct7_5_i && (funct3_i != 3'b000) && (funct3_i != 3'b101);
            end
            CLS_OP_IMM: begin
                // bit 30 is immediate data except for the right shifts
                alu_op_o   = base_op(funct3_i, funct7_5_i && (funct3_i == 3'b101));
                src2_imm_o = 1'b1;
            end
            CLS_OP_32: begin
                alu_op_o  = base_op(funct3_i, funct7_5_i);
                word_o    = 1'b1;
                illegal_o = !(funct3_i inside {3'b000, 3'b001, 3'b101}) ||
                            (funct7_5_i && (funct3_i == 3'b001));
            end
            CLS_OP_IMM_32: begin
                // addiw, slliw, srliw, sraiw
                alu_op_o   = base_op(funct3_i, funct7_5_i && (funct3_i == 3'b101));
                word_o     = 1'b1;
                src2_imm_o = 1'b1;
                illegal_o  = !(funct3_i inside {3'b000, 3'b001, 3'b101});
            end
            CLS_BRANCH: begin
                case (funct3_i)
                    3'b000: begin
                        alu_op_o = ALU_SUB;
                        br_sel_o = BR_EQ;
                    end
                    3'b001: begin
                        alu_op_o = ALU_SUB;
                        br_sel_o = BR_NE;
                    end
                    3'b100: begin
                        alu_op_o = ALU_SLT;
                        br_sel_o = BR_LT;
                    end
                    3'b101: begin
                        alu_op_o = ALU_SLT;
                        br_sel_o = BR_GE;
                    end
                    3'b110: begin
                        alu_op_o = ALU_SLTU;
                        br_sel_o = BR_LT;
                    end
                    3'b111: begin
                        alu_op_o = ALU_SLTU;
                        br_sel_o = BR_GE;
                    end
                    default: illegal_o = 1'b1;
                endcase
            end
            CLS_LUI: begin
                alu_op_o   = ALU_PASS2;
                src2_imm_o = 1'b1;
            end
            CLS_AUIPC: begin
                alu_op_o   = ALU_ADD;
                src1_pc_o  = 1'b1;
                src2_imm_o = 1'b1;
            end
            default: illegal_o = 1'b1;
        endcase

        // unsupported encodings fall back to a plain add
        if (illegal_o) begin
            alu_op_o   = ALU_ADD;
            word_o     = 1'b0;
            src1_pc_o  = 1'b0;
            src2_imm_o = 1'b0;
            br_sel_o   = BR_NONE;
        end
    end

endmodule

`default_nettype wire

// File: hdl/alu_shifter.sv
`timescale 1ns/1ps
`default_nettype none

module alu_shifter import exec_pkg::*; (
    input  logic [XLEN-1:0]    data_i,
    input  logic [SHAMT_W-1:0] shamt_i,
    input  logic               right_i,
    input  logic               arith_i,
    output logic [XLEN-1:0]    data_o
);

    // stage k holds the value after shamt bits 0..k-1 are applied
    logic [XLEN-1:0] stage [SHAMT_W+1];
    logic            fill;

    // sign fill only for arithmetic right shifts
    assign fill = arith_i & right_i & data_i[XLEN-1];

    assign stage[0] = data_i;

    // log stages of 1, 2, 4, 8, 16, 32 bits
    for (genvar i = 0; i < SHAMT_W; i++) begin : g_stage
        localparam int unsigned N = 2 ** i;

        logic [XLEN-1:0] shl;
        logic [XLEN-1:0] shr;

        assign shl = {stage[i][XLEN-1-N:0], {N{1'b0}}};
        assign shr = {{N{fill}}, stage[i][XLEN-1:N]};

        assign stage[i+1] = !shamt_i[i] ? stage[i] :
                            right_i     ? shr      :
                                          shl;
    end

    assign data_o = stage[SHAMT_W];

endmodule

`default_nettype wire

// File: hdl/exec_pkg.sv
`default_nettype none

package exec_pkg;

    // datapath width and shift amount width
    localparam int unsigned XLEN    = 64;
    localparam int unsigned SHAMT_W = 6;
    // width of the *W instruction forms
    localparam int unsigned WORD_W  = 32;

    // instruction class, code 3'b111 is never legal
    typedef enum logic [2:0] {
        CLS_OP        = 3'd0,
        CLS_OP_IMM    = 3'd1,
        CLS_OP_32     = 3'd2,
        CLS_OP_IMM_32 = 3'd3,
        CLS_BRANCH    = 3'd4,
        CLS_LUI       = 3'd5,
        CLS_AUIPC     = 3'd6
    } inst_class_e;

    // bit 3 is the modifier, bits 2:0 pick the output
    typedef enum logic [3:0] {
        ALU_ADD   = 4'b0000,
        ALU_SUB   = 4'b1000,
        ALU_SLL   = 4'b0001,
        ALU_SLT   = 4'b0010,
        ALU_SLTU  = 4'b1010,
        ALU_PASS2 = 4'b0011,
        ALU_XOR   = 4'b0100,
        ALU_SRL   = 4'b0101,
        ALU_SRA   = 4'b1101,
        ALU_OR    = 4'b0110,
        ALU_AND   = 4'b0111
    } alu_op_e;

    // branch condition on the zero and less flags
    typedef enum logic [2:0] {
        BR_NONE = 3'd0,
        BR_EQ   = 3'd1,
        BR_NE   = 3'd2,
        BR_LT   = 3'd3,
        BR_GE   = 3'd4
    } br_sel_e;

endpackage

`default_nettype wire

// File: hdl/exec_stage.sv
`timescale 1ns/1ps
`default_nettype none

module exec_stage import exec_pkg::*; (
    input  logic            clk_i,
    input  logic            arst_n_i,

    input  logic            valid_i,
    input  inst_class_e     cls_i,
    input  logic [2:0]      funct3_i,
    input  logic            funct7_5_i,
    input  logic [XLEN-1:0] rs1_i,
    input  logic [XLEN-1:0] rs2_i,
    input  logic [XLEN-1:0] imm_i,
    input  logic [XLEN-1:0] pc_i,

    output logic            valid_o,
    output logic [XLEN-1:0] result_o,
    output logic            branch_taken_o,
    output logic            illegal_o
);

    alu_op_e         alu_op;
    logic            word;
    logic            src1_pc;
    logic            src2_imm;
    br_sel_e         br_sel;
    logic            illegal;

    logic [XLEN-1:0] src1;
    logic [XLEN-1:0] src2;
    logic [XLEN-1:0] alu_result;
    logic            less;
    logic            zero;
    logic            taken;

    alu_ctrl i_alu_ctrl (
        .cls_i      (cls_i),
        .funct3_i   (funct3_i),
        .funct7_5_i (funct7_5_i),
        .alu_op_o   (alu_op),
        .word_o     (word),
        .src1_pc_o  (src1_pc),
        .src2_imm_o (src2_imm),
        .br_sel_o   (br_sel),
        .illegal_o  (illegal)
    );

    // operand select
    assign src1 = src1_pc  ? pc_i  : rs1_i;
    assign src2 = src2_imm ? imm_i : rs2_i;

    alu i_alu (
        .alu_op_i (alu_op),
        .word_i   (word),
        .src1_i   (src1),
        .src2_i   (src2),
        .result_o (alu_result),
        .less_o   (less),
        .zero_o   (zero)
    );

    // branch resolve
    always_comb begin
        case (br_sel)
            BR_EQ:   taken = zero;
            BR_NE:   taken = ~zero;
            BR_LT:   taken = less;
            BR_GE:   taken = ~less;
            default: taken = 1'b0;
        endcase
    end

    // one-cycle output register, result holds between instructions
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            valid_o        <= 1'b0;
            result_o       <= '0;
            branch_taken_o <= 1'b0;
            illegal_o      <= 1'b0;
        end else begin
            valid_o        <= valid_i;
            branch_taken_o <= valid_i & taken & ~illegal;
            illegal_o      <= valid_i & illegal;
            if (valid_i) begin
                result_o <= illegal ? '0 : alu_result;
            end
        end
    end

endmodule

`default_nettype wire

// File: run.sh
#!/bin/sh
# builds the execute stage testbench with Verilator and runs it
# the exit status is nonzero when the simulation fails

cd "$(dirname "$0")" \
    && verilator --binary --timing --assert -f tb.f --top-module exec_stage_tb \
        -o exec_stage_tb \
    && ./obj_dir/exec_stage_tb \
    || { echo "simulation did not complete cleanly"; exit 1; }

// File: tb.f
hdl/exec_pkg.sv
hdl/alu_adder.sv
hdl/alu_shifter.sv
hdl/alu_ctrl.sv
hdl/alu.sv
hdl/exec_stage.sv
verif/exec_stage_asserts.sv
verif/exec_stage_tb.sv

// File: verif/exec_stage_asserts.sv
`timescale 1ns/1ps
`default_nettype none

module exec_stage_asserts import exec_pkg::*; (
    input logic            clk_i,
    input logic            arst_n_i,
    input logic            valid_i,
    input logic            valid_o,
    input logic [XLEN-1:0] result_o,
    input logic            branch_taken_o,
    input logic            illegal_o
);

    // output qualifier trails the input by exactly one clock
    a_valid_delay: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        valid_o == $past(valid_i))
        else $error("valid_o does not follow valid_i by one cycle");

    a_reset_quiet: assert property (@(posedge clk_i)
        !arst_n_i |-> !valid_o && !branch_taken_o && !illegal_o)
        else $error("outputs active during reset");

    // flags only ride along with a valid result
    a_flags_valid: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        (branch_taken_o || illegal_o) |-> valid_o)
        else $error("branch or illegal flag without valid_o");

    a_illegal_zero: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        illegal_o |-> (result_o == '0))
        else $error("illegal instruction with nonzero result");

endmodule

bind exec_stage exec_stage_asserts i_exec_stage_asserts (
    .clk_i          (clk_i),
    .arst_n_i       (arst_n_i),
    .valid_i        (valid_i),
    .valid_o        (valid_o),
    .result_o       (result_o),
    .branch_taken_o (branch_taken_o),
    .illegal_o      (illegal_o)
);

`default_nettype wire

// File: verif/exec_stage_tb.sv
`timescale 1ns/1ps
`default_nettype none

module exec_stage_tb import exec_pkg::*; ();

    localparam int CLK_PERIOD   = 40;
    localparam int RESET_CYCLES = 16;
    localparam int N_RANDOM     = 400;
    // corner ops, shifts, word adds, branches, lui/auipc, illegal, random stream
    localparam int N_TESTS = 25 * 13 + 64 * 12 + 16 * 3 + 6 * 18 + 16 * 2 + 4 + N_RANDOM;
    localparam int WATCHDOG_NS = (N_TESTS * 2 + RESET_CYCLES + 8) * CLK_PERIOD;

    logic            clk_i;
    logic            arst_n_i;
    logic            valid_i;
    inst_class_e     cls_i;
    logic [2:0]      funct3_i;
    logic            funct7_5_i;
    logic [XLEN-1:0] rs1_i;
    logic [XLEN-1:0] rs2_i;
    logic [XLEN-1:0] imm_i;
    logic [XLEN-1:0] pc_i;
    logic            valid_o;
    logic [XLEN-1:0] result_o;
    logic            branch_taken_o;
    logic            illegal_o;

    integer          seed = 32'h3288_67cc;
    // {illegal, taken, result} per valid instruction
    logic [XLEN+1:0] exp_q [$];
    logic            sent_q;
    logic [XLEN-1:0] last_res = '0;

    exec_stage i_exec_stage (
        .clk_i          (clk_i),
        .arst_n_i       (arst_n_i),
        .valid_i        (valid_i),
        .cls_i          (cls_i),
        .funct3_i       (funct3_i),
        .funct7_5_i     (funct7_5_i),
        .rs1_i          (rs1_i),
        .rs2_i          (rs2_i),
        .imm_i          (imm_i),
        .pc_i           (pc_i),
        .valid_o        (valid_o),
        .result_o       (result_o),
        .branch_taken_o (branch_taken_o),
        .illegal_o      (illegal_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
    end

    task automatic check_val(input string name, input logic [XLEN-1:0] got,
                             input logic [XLEN-1:0] exp);
        if (got !== exp) begin
            $display("FAIL %s got 0x%h expected 0x%h", name, got, exp);
            $display("test failed");
            $fatal(1);
        end
    endtask

    function automatic logic [XLEN-1:0] rand_word();
        return {$random(seed), $random(seed)};
    endfunction

    function automatic logic [XLEN+1:0] ref_exec(input logic [2:0] cls, input logic [2:0] f3,
            input logic f7, input logic [XLEN-1:0] rs1, input logic [XLEN-1:0] rs2,
            input logic [XLEN-1:0] imm, input logic [XLEN-1:0] pc);
        logic [XLEN-1:0] b;
        logic [XLEN-1:0] res;
        logic [31:0]     w;
        logic [5:0]      sh;
        logic            ill;
        logic            tk;
        logic            less;
        res = '0;
        ill = 1'b0;
        tk  = 1'b0;
        b   = (cls == CLS_OP || cls == CLS_OP_32) ? rs2 : imm;
        sh  = b[5:0];
        case (cls)
            CLS_OP, CLS_OP_IMM: begin
                // bit 30 only qualifies sub and the right shifts
                ill = (cls == CLS_OP) && f7 && !(f3 inside {3'b000, 3'b101});
                case (f3)
                    3'b000:  res = (cls == CLS_OP && f7) ? rs1 - b : rs1 + b;
                    3'b001:  res = rs1 << sh;
                    3'b010:  res = {{(XLEN-1){1'b0}}, $signed(rs1) < $signed(b)};
                    3'b011:  res = {{(XLEN-1){1'b0}}, rs1 < b};
                    3'b100:  res = rs1 ^ b;
                    3'b101: begin
                        if (f7)
                            res = $signed(rs1) >>> sh;
                        else
                            res = rs1 >> sh;
                    end
                    3'b110:  res = rs1 | b;
                    default: res = rs1 & b;
                endcase
            end
            CLS_OP_32, CLS_OP_IMM_32: begin
                ill = !(f3 inside {3'b000, 3'b001, 3'b101}) ||
                      (cls == CLS_OP_32 && f7 && f3 == 3'b001);
                case (f3)
                    3'b000:  w = (cls == CLS_OP_32 && f7) ? rs1[31:0] - b[31:0]
                                                          : rs1[31:0] + b[31:0];
                    3'b001:  w = rs1[31:0] << sh[4:0];
                    default: begin
                        if (f7)
                            w = $signed(rs1[31:0]) >>> sh[4:0];
                        else
                            w = rs1[31:0] >> sh[4:0];
                    end
                endcase
                res = {{(XLEN-32){w[31]}}, w};
            end
            CLS_BRANCH: begin
                ill  = f3 inside {3'b010, 3'b011};
                less = f3[1] ? (rs1 < rs2) : ($signed(rs1) < $signed(rs2));
                // eq/ne compare through a subtract, the rest through slt/sltu
                if (f3[2]) begin
                    res = {{(XLEN-1){1'b0}}, less};
                    tk  = f3[0] ? !less : less;
                end else begin
                    res = rs1 - rs2;
                    tk  = f3[0] ? (rs1 != rs2) : (rs1 == rs2);
                end
            end
            CLS_LUI:   res = imm;
            CLS_AUIPC: res = pc + imm;
            default:   ill = 1'b1;
        endcase
        if (ill) begin
            res = '0;
            tk  = 1'b0;
        end
        return {ill, tk, res};
    endfunction

    task automatic send_instr(input logic [2:0] cls, input logic [2:0] f3, input logic f7,
                              input logic [XLEN-1:0] rs1, input logic [XLEN-1:0] rs2,
                              input logic [XLEN-1:0] imm, input logic [XLEN-1:0] pc);
        // roughly one slot in four is a bubble
        if (($random(seed) & 3) == 0) begin
            valid_i = 1'b0;
            @(negedge clk_i);
        end
        valid_i    = 1'b1;
        cls_i      = inst_class_e'(cls);
        funct3_i   = f3;
        funct7_5_i = f7;
        rs1_i      = rs1;
        rs2_i      = rs2;
        imm_i      = imm;
        pc_i       = pc;
        exp_q.push_back(ref_exec(cls, f3, f7, rs1, rs2, imm, pc));
        @(negedge clk_i);
    endtask

    // qualifier as it went into the stage one edge ago
    always @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i)
            sent_q <= 1'b0;
        else
            sent_q <= valid_i;
    end

    // outputs are sampled on the falling edge, half a cycle after they settle
    initial begin
        logic [XLEN+1:0] item;
        @(posedge arst_n_i);
        forever begin
            @(negedge clk_i);
            check_val("valid_o", XLEN'(valid_o), XLEN'(sent_q));
            if (valid_o) begin
                if (exp_q.size() == 0) begin
                    $display("unexpected output with no instruction pending");
                    $display("test failed");
                    $fatal(1);
                end
                item = exp_q.pop_front();
                check_val("result_o", result_o, item[XLEN-1:0]);
                check_val("branch_taken_o", XLEN'(branch_taken_o), XLEN'(item[XLEN]));
                check_val("illegal_o", XLEN'(illegal_o), XLEN'(item[XLEN+1]));
                last_res = item[XLEN-1:0];
            end else begin
                check_val("branch_taken_o", XLEN'(branch_taken_o), XLEN'(1'b0));
                check_val("illegal_o", XLEN'(illegal_o), XLEN'(1'b0));
                check_val("result_o", result_o, last_res);
            end
        end
    end

    initial begin
        #(WATCHDOG_NS);
        $display("timeout, the stage stopped producing results");
        $display("test failed");
        $fatal(1);
    end

    initial begin
        logic [XLEN-1:0] corner [5];
        logic [3:0]      r_ops [7];
        logic [2:0]      i_ops [6];
        logic [2:0]      br_f3 [6];
        logic [XLEN-1:0] a;
        logic [XLEN-1:0] b;
        arst_n_i   = 1'b0;
        valid_i    = 1'b0;
        cls_i      = CLS_OP;
        funct3_i   = 3'b000;
        funct7_5_i = 1'b0;
        rs1_i      = '0;
        rs2_i      = '0;
        imm_i      = '0;
        pc_i       = '0;
        corner = '{{XLEN{1'b0}}, {XLEN{1'b1}}, {1'b1, {(XLEN-1){1'b0}}},
                   {1'b0, {(XLEN-1){1'b1}}}, XLEN'(1)};
        // {funct7_5, funct3}
        r_ops = '{4'b0000, 4'b1000, 4'b0010, 4'b0011, 4'b0100, 4'b0110, 4'b0111};
        i_ops = '{3'b000, 3'b010, 3'b011, 3'b100, 3'b110, 3'b111};
        br_f3 = '{3'b000, 3'b001, 3'b100, 3'b101, 3'b110, 3'b111};
        repeat (RESET_CYCLES) @(negedge clk_i);
        arst_n_i = 1'b1;

        // register and immediate ops on corner operands
        for (int x = 0; x < 5; x++) begin
            for (int y = 0; y < 5; y++) begin
                for (int k = 0; k < 7; k++)
                    send_instr(CLS_OP, r_ops[k][2:0], r_ops[k][3], corner[x], corner[y],
                               rand_word(), rand_word());
                for (int k = 0; k < 6; k++)
                    send_instr(CLS_OP_IMM, i_ops[k], 1'b0, corner[x], rand_word(),
                               corner[y], rand_word());
            end
        end

        // every shift amount, upper amount bits random, 64-bit and word forms
        for (int s = 0; s < 64; s++) begin
            a = rand_word();
            b = rand_word();
            b[5:0] = 6'(s);
            for (int w = 0; w < 2; w++) begin
                send_instr(w ? CLS_OP_32 : CLS_OP, 3'b001, 1'b0, a, b, rand_word(), '0);
                send_instr(w ? CLS_OP_32 : CLS_OP, 3'b101, 1'b0, a, b, rand_word(), '0);
                send_instr(w ? CLS_OP_32 : CLS_OP, 3'b101, 1'b1, a, b, rand_word(), '0);
                send_instr(w ? CLS_OP_IMM_32 : CLS_OP_IMM, 3'b001, 1'b0, a, rand_word(), b, '0);
                send_instr(w ? CLS_OP_IMM_32 : CLS_OP_IMM, 3'b101, 1'b0, a, rand_word(), b, '0);
                send_instr(w ? CLS_OP_IMM_32 : CLS_OP_IMM, 3'b101, 1'b1, a, rand_word(), b, '0);
            end
        end

        // addw, subw, addiw
        for (int i = 0; i < 16; i++) begin
            send_instr(CLS_OP_32, 3'b000, 1'b0, rand_word(), rand_word(), rand_word(), '0);
            send_instr(CLS_OP_32, 3'b000, 1'b1, rand_word(), rand_word(), rand_word(), '0);
            send_instr(CLS_OP_IMM_32, 3'b000, 1'b0, rand_word(), rand_word(), rand_word(), '0);
        end

        // branches: equal, sign bit apart, random pairs
        for (int k = 0; k < 6; k++) begin
            a = rand_word();
            send_instr(CLS_BRANCH, br_f3[k], 1'b0, a, a, rand_word(), rand_word());
            send_instr(CLS_BRANCH, br_f3[k], 1'b0, a, a ^ {1'b1, {(XLEN-1){1'b0}}},
                       rand_word(), rand_word());
            for (int i = 0; i < 16; i++)
                send_instr(CLS_BRANCH, br_f3[k], 1'b0, rand_word(), rand_word(),
                           rand_word(), rand_word());
        end

        for (int i = 0; i < 16; i++) begin
            send_instr(CLS_LUI, 3'($random(seed)), 1'b0, rand_word(), rand_word(),
                       rand_word(), rand_word());
            send_instr(CLS_AUIPC, 3'($random(seed)), 1'b0, rand_word(), rand_word(),
                       rand_word(), rand_word());
        end

        // unused class, or with bit 30, xorw, branch funct3 010
        send_instr(3'b111, 3'b000, 1'b0, rand_word(), rand_word(), rand_word(), rand_word());
        send_instr(CLS_OP, 3'b110, 1'b1, rand_word(), rand_word(), rand_word(), rand_word());
        send_instr(CLS_OP_32, 3'b100, 1'b0, rand_word(), rand_word(), rand_word(), rand_word());
        send_instr(CLS_BRANCH, 3'b010, 1'b0, rand_word(), rand_word(), rand_word(), rand_word());

        for (int i = 0; i < N_RANDOM; i++)
            send_instr(3'($random(seed)), 3'($random(seed)), 1'($random(seed)), rand_word(),
                       rand_word(), rand_word(), rand_word());

        valid_i = 1'b0;
        while (exp_q.size() != 0)
            @(negedge clk_i);
        repeat (2) @(negedge clk_i);
        $display("test passed");
        $finish;
    end

endmodule

`default_nettype wire
